// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_cache
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sources.f ====
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_req_if.sv
verilog/bus_event_queue.sv
verilog/apb_cmd_port.sv
verilog/plru_tree.sv
verilog/mesi_lookup.sv
verilog/cache_top.sv
testbench/tb_cache.sv

// ==== testbench/tb_cache.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module tb_cache;
	localparam int N_REQ      = 80; // Upper bound on requests issued in the run
	localparam int MAX_CYCLES = N_REQ * 20;

	logic        w_eof;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        bus_valid;
	logic        bus_ready;
	cache_pkg::bus_op_e bus_op;
	logic [31:0] bus_addr;
	cache_pkg::snoop_e  bus_snoop;

	// Reference model of tags, states and trees
	logic [`TAG_W-1:0]  m_tag   [`CACHE_SETS][`CACHE_WAYS];
	cache_pkg::mesi_e   m_state [`CACHE_SETS][`CACHE_WAYS];
	logic [`PLRU_W-1:0] m_tree  [`CACHE_SETS];
	int                 m_reads;
	int                 m_writes;
	int                 m_hits;

	cache_pkg::bus_evt_t exp_q [$];
	cache_pkg::bus_evt_t head;
	int                  val_errs;
	int                  other_errs;
	int                  cycles;
	logic                hold_ready;
	logic                cmd_done;

	cache_top dut (
		.w_eof     (w_eof),
		.rst       (rst),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.bus_valid (bus_valid),
		.bus_ready (bus_ready),
		.bus_op    (bus_op),
		.bus_addr  (bus_addr),
		.bus_snoop (bus_snoop)
	);

	initial begin
		w_eof = 1'b0;
		forever #20 w_eof = ~w_eof;
	end

	function automatic logic [31:0] make_addr(input logic [21:0] tag, input logic [3:0] idx,
		input logic [1:0] lo);
		return {tag, idx, 4'b0000, lo};
	endfunction

	// Heap layout with children of node n at 2n+1 and 2n+2
	function automatic logic [2:0] plru_victim(input logic [6:0] t);
		logic [2:0] v;
		int         node;
		node = 0;
		for (int lvl = 2; lvl >= 0; lvl--) begin
			v[lvl] = ~t[node];
			node   = 2 * node + 1 + int'(v[lvl]);
		end
		return v;
	endfunction

	function automatic logic [6:0] plru_touch(input logic [6:0] t, input logic [2:0] w);
		logic [6:0] r;
		int         node;
		r    = t;
		node = 0;
		for (int lvl = 2; lvl >= 0; lvl--) begin
			r[node] = w[lvl];
			node    = 2 * node + 1 + int'(w[lvl]);
		end
		return r;
	endfunction

	function automatic void push_event(input cache_pkg::bus_op_e op, input logic [31:0] a,
		input cache_pkg::snoop_e sn);
		cache_pkg::bus_evt_t ev;
		ev.op       = op;
		ev.addr.raw = a;
		ev.snoop    = sn;
		exp_q.push_back(ev);
	endfunction

	// Expected effect of one accepted command
	function automatic void model_request(input logic [3:0] cmd, input logic [31:0] a);
		logic [`TAG_W-1:0]   tag;
		logic [`INDEX_W-1:0] idx;
		logic                hit;
		logic                is_rd;
		logic                is_wr;
		logic [2:0]          w;
		cache_pkg::mesi_e    st;
		cache_pkg::snoop_e   reply;
		tag   = a[31 -: `TAG_W];
		idx   = a[`OFFSET_W +: `INDEX_W];
		is_rd = cmd == cache_pkg::DATA_READ || cmd == cache_pkg::INST_READ;
		is_wr = cmd == cache_pkg::DATA_WRITE;
		hit   = 1'b0;
		w     = '0;
		if (cmd == cache_pkg::CLEAR_CACHE) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				m_tree[s] = '0;
				for (int k = 0; k < `CACHE_WAYS; k++)
					m_state[s][k] = cache_pkg::I;
			end
			return;
		end
		for (int k = 0; k < `CACHE_WAYS; k++) begin
			if (m_state[idx][k] != cache_pkg::I && m_tag[idx][k] == tag) begin
				hit = 1'b1;
				w   = 3'(k);
			end
		end
		st = m_state[idx][w];
		if (is_rd || is_wr) begin
			if (is_rd)
				m_reads++;
			else
				m_writes++;
			if (hit) begin
				m_hits++;
				if (is_wr && st == cache_pkg::S)
					push_event(cache_pkg::BUS_INVALIDATE, a, cache_pkg::NOHIT);
				if (is_wr)
					m_state[idx][w] = cache_pkg::M;
			end else begin
				w = plru_victim(m_tree[idx]);
				if (m_state[idx][w] == cache_pkg::M) // Dirty victim written back first
					push_event(cache_pkg::BUS_WRITE, {m_tag[idx][w], idx, 6'b0}, cache_pkg::NOHIT);
				push_event(is_wr ? cache_pkg::BUS_RWIM : cache_pkg::BUS_READ, a, cache_pkg::NOHIT);
				m_tag[idx][w] = tag;
				if (is_wr)
					m_state[idx][w] = cache_pkg::M;
				else if (a[1:0] == 2'b00 || a[1:0] == 2'b01)
					m_state[idx][w] = cache_pkg::S;
				else
					m_state[idx][w] = cache_pkg::E;
			end
			m_tree[idx] = plru_touch(m_tree[idx], w);
		end else begin
			if (!hit)
				reply = cache_pkg::NOHIT;
			else if (st == cache_pkg::M)
				reply = cache_pkg::HITM;
			else
				reply = cache_pkg::HIT;
			push_event(cache_pkg::SNOOP_REPLY, a, reply);
			if (hit && cmd == cache_pkg::SNOOP_READ)
				m_state[idx][w] = cache_pkg::S;
			else if (hit && cmd == cache_pkg::SNOOP_RWIM)
				m_state[idx][w] = cache_pkg::I;
			else if (hit && st == cache_pkg::S)
				m_state[idx][w] = cache_pkg::I;
		end
	endfunction

	task automatic apb_write(input logic [7:0] a, input logic [31:0] d, output logic err);
		@(posedge w_eof);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= a;
		pwdata  <= d;
		@(posedge w_eof);
		penable <= 1'b1;
		@(negedge w_eof);
		while (pready !== 1'b1)
			@(negedge w_eof);
		err = pslverr;
		@(posedge w_eof);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic err);
		@(posedge w_eof);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= a;
		@(posedge w_eof);
		penable <= 1'b1;
		@(negedge w_eof);
		while (pready !== 1'b1)
			@(negedge w_eof);
		d   = prdata;
		err = pslverr;
		@(posedge w_eof);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic send_request(input logic [3:0] cmd, input logic [31:0] a);
		logic err;
		apb_write(`REG_ADDR, a, err);
		model_request(cmd, a);
		apb_write(`REG_CMD, {28'b0, cmd}, err);
		if (err !== 1'b0) begin
			val_errs++;
			$display("Error pslverr: got %h expected %h", err, 1'b0);
		end
	endtask

	task automatic compare_register(input logic [7:0] a, input int expected, input string name);
		logic [31:0] d;
		logic        err;
		apb_read(a, d, err);
		if (d !== 32'(expected)) begin
			val_errs++;
			$display("Error prdata (%s): got %h expected %h", name, d, 32'(expected));
		end
	endtask

	task automatic wait_drain();
		@(negedge w_eof);
		while (bus_valid || exp_q.size() != 0)
			@(negedge w_eof);
	endtask

	// Random back-pressure unless a test holds it low
	always @(posedge w_eof) begin
		if (rst || hold_ready)
			bus_ready <= 1'b0;
		else
			bus_ready <= ($urandom % 4) != 0;
	end

	// Handshake completes on the next rising edge
	always @(negedge w_eof) begin
		if (!rst && bus_valid && bus_ready) begin
			if (exp_q.size() == 0) begin
				other_errs++;
				$display("Bus event at address %h came out with none expected", bus_addr);
			end else begin
				head = exp_q.pop_front();
				if (bus_op !== head.op) begin
					val_errs++;
					$display("Error bus_op: got %h expected %h", bus_op, head.op);
				end
				if (bus_addr !== head.addr.raw) begin
					val_errs++;
					$display("Error bus_addr: got %h expected %h", bus_addr, head.addr.raw);
				end
				if (head.op == cache_pkg::SNOOP_REPLY && bus_snoop !== head.snoop) begin
					val_errs++;
					$display("Error bus_snoop: got %h expected %h", bus_snoop, head.snoop);
				end
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge w_eof);
			cycles++;
		end
		$display("Run did not finish within %0d cycles", MAX_CYCLES);
		$display("Value errors: %0d, other errors: %0d", val_errs, other_errs + 1);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		logic [31:0] a;
		logic [31:0] d;
		logic [3:0]  c;
		logic        err;
		int          pick;
		void'($urandom(32'h432d));
		rst        = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		bus_ready  = 1'b0;
		hold_ready = 1'b0;
		cmd_done   = 1'b0;
		val_errs   = 0;
		other_errs = 0;
		m_reads    = 0;
		m_writes   = 0;
		m_hits     = 0;
		model_request(cache_pkg::CLEAR_CACHE, '0);
		repeat (5) @(posedge w_eof);
		rst <= 1'b0;

		// Fill as S and as E, hit, then upgrade both
		send_request(cache_pkg::DATA_READ, make_addr(22'h11, 4'd1, 2'd0));
		send_request(cache_pkg::DATA_READ, make_addr(22'h11, 4'd1, 2'd0));
		send_request(cache_pkg::INST_READ, make_addr(22'h12, 4'd2, 2'd2));
		wait_drain();
		compare_register(`REG_HITS, m_hits, "hit counter");
		send_request(cache_pkg::DATA_WRITE, make_addr(22'h11, 4'd1, 2'd0));
		send_request(cache_pkg::DATA_WRITE, make_addr(22'h12, 4'd2, 2'd2));

		// Nine tags through one set
		for (int t = 0; t < 9; t++)
			send_request(cache_pkg::DATA_READ, make_addr(22'h200 + 22'(t), 4'd5, 2'(t)));
		for (int t = 0; t < 9; t++)
			send_request(cache_pkg::DATA_WRITE, make_addr(22'h200 + 22'(t), 4'd5, 2'(t)));

		send_request(cache_pkg::DATA_READ, make_addr(22'h300, 4'd3, 2'd0));
		send_request(cache_pkg::DATA_WRITE, make_addr(22'h300, 4'd3, 2'd0));
		send_request(cache_pkg::SNOOP_READ, make_addr(22'h300, 4'd3, 2'd0));
		send_request(cache_pkg::SNOOP_INVALIDATE, make_addr(22'h300, 4'd3, 2'd0));
		send_request(cache_pkg::DATA_READ, make_addr(22'h301, 4'd3, 2'd2));
		send_request(cache_pkg::SNOOP_RWIM, make_addr(22'h301, 4'd3, 2'd2));
		send_request(cache_pkg::SNOOP_RWIM, make_addr(22'h302, 4'd3, 2'd0));

		// Queue fills under back-pressure and the next command stalls
		wait_drain();
		send_request(cache_pkg::CLEAR_CACHE, '0);
		@(posedge w_eof);
		hold_ready <= 1'b1;
		send_request(cache_pkg::DATA_READ, make_addr(22'h500, 4'd10, 2'd0));
		send_request(cache_pkg::DATA_READ, make_addr(22'h501, 4'd11, 2'd1));
		send_request(cache_pkg::DATA_READ, make_addr(22'h502, 4'd12, 2'd2));
		fork
			begin
				send_request(cache_pkg::DATA_WRITE, make_addr(22'h503, 4'd13, 2'd3));
				cmd_done = 1'b1;
			end
			begin
				repeat (10) @(negedge w_eof);
				if (cmd_done) begin
					other_errs++;
					$display("Command write finished while the event queue was full");
				end
				if (pready !== 1'b0) begin
					val_errs++;
					$display("Error pready: got %h expected %h", pready, 1'b0);
				end
				@(posedge w_eof);
				hold_ready <= 1'b0;
			end
		join

		for (int n = 0; n < 40; n++) begin
			pick = int'($urandom % 6);
			c    = pick == 5 ? cache_pkg::SNOOP_RWIM : 4'(pick);
			a    = make_addr(22'h400 + 22'($urandom % 12), 4'($urandom % 4), 2'($urandom % 4));
			send_request(c, a);
		end

		send_request(cache_pkg::DATA_READ, make_addr(22'h500, 4'd10, 2'd0));
		send_request(cache_pkg::CLEAR_CACHE, '0);
		send_request(cache_pkg::DATA_READ, make_addr(22'h500, 4'd10, 2'd0));
		wait_drain();
		compare_register(`REG_RDS, m_reads, "read counter");
		compare_register(`REG_WRS, m_writes, "write counter");
		compare_register(`REG_HITS, m_hits, "hit counter");
		apb_write(`REG_RDS, 32'h1, err);
		if (err !== 1'b1) begin
			val_errs++;
			$display("Error pslverr: got %h expected %h", err, 1'b1);
		end
		apb_read(8'h20, d, err); // Unmapped offset
		if (err !== 1'b1) begin
			val_errs++;
			$display("Error pslverr: got %h expected %h", err, 1'b1);
		end
		apb_write(`REG_CMD, 32'h5, err);
		if (err !== 1'b1) begin
			val_errs++;
			$display("Error pslverr: got %h expected %h", err, 1'b1);
		end
		repeat (4) @(posedge w_eof);

		$display("Value errors: %0d, other errors: %0d", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/apb_cmd_port.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module apb_cmd_port (
	input  logic        w_eof,
	input  logic        rst,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	cache_req_if.port   req
);
	logic                   access;
	logic                   cmd_sel;
	logic                   cmd_legal;
	logic                   bad_access;
	logic                   taken;
	cache_pkg::cache_addr_u addr_reg;
	logic [31:0]            rd_count;
	logic [31:0]            wr_count;
	logic [31:0]            hit_count;

	assign access  = psel && penable;
	assign cmd_sel = access && pwrite && paddr == `REG_CMD;

	always_comb begin
		cmd_legal = 1'b0;
		if (pwdata[31:4] == '0) begin
			case (pwdata[3:0])
				cache_pkg::DATA_READ,
				cache_pkg::DATA_WRITE,
				cache_pkg::INST_READ,
				cache_pkg::SNOOP_INVALIDATE,
				cache_pkg::SNOOP_READ,
				cache_pkg::SNOOP_RWIM,
				cache_pkg::CLEAR_CACHE: cmd_legal = 1'b1;
				default:                cmd_legal = 1'b0;
			endcase
		end
	end

	always_comb begin
		case (paddr)
			`REG_ADDR:                    bad_access = 1'b0;
			`REG_CMD:                     bad_access = pwrite && !cmd_legal;
			`REG_RDS, `REG_WRS, `REG_HITS: bad_access = pwrite; // Counters are read only
			default:                      bad_access = 1'b1;
		endcase
	end

	// Request held by the APB access phase itself
	assign req.valid = cmd_sel && cmd_legal;
	assign req.cmd   = cache_pkg::cache_cmd_e'(pwdata[3:0]);
	assign req.addr  = addr_reg;
	assign taken     = req.valid && req.ready;

	assign pready  = req.valid ? req.ready : 1'b1; // Stretch until lookup accepts
	assign pslverr = access && bad_access;

	always_comb begin
		case (paddr)
			`REG_ADDR: prdata = addr_reg.raw;
			`REG_RDS:  prdata = rd_count;
			`REG_WRS:  prdata = wr_count;
			`REG_HITS: prdata = hit_count;
			default:   prdata = '0;
		endcase
	end

	always_ff @(posedge w_eof) begin
		if (access && pwrite && paddr == `REG_ADDR)
			addr_reg.raw <= pwdata;
	end

	always_ff @(posedge w_eof) begin
		if (rst) begin
			rd_count  <= '0;
			wr_count  <= '0;
			hit_count <= '0;
		end else begin
			if (taken && (req.cmd == cache_pkg::DATA_READ || req.cmd == cache_pkg::INST_READ))
				rd_count <= rd_count + 1'b1;
			if (taken && req.cmd == cache_pkg::DATA_WRITE)
				wr_count <= wr_count + 1'b1;
			if (req.hit_valid && req.hit)
				hit_count <= hit_count + 1'b1;
		end
	end

	a_req_hold: assert property (@(posedge w_eof) disable iff (rst)
		req.valid && !req.ready |=> req.valid && $stable(req.cmd) && $stable(req.addr))
		else $error("request dropped or changed before acceptance");

endmodule

// ==== verilog/bus_event_queue.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

interface bus_evt_if;
	logic                push0;
	cache_pkg::bus_evt_t evt0;
	logic                push1;
	cache_pkg::bus_evt_t evt1;
	logic                room; // Two or more entries free

	modport src (output push0, evt0, push1, evt1, input room);
	modport sink (input push0, evt0, push1, evt1, output room);
endinterface

module bus_event_queue (
	input  logic               w_eof,
	input  logic               rst,
	bus_evt_if.sink            evt,
	output logic               bus_valid,
	input  logic               bus_ready,
	output cache_pkg::bus_op_e bus_op,
	output logic [31:0]        bus_addr,
	output cache_pkg::snoop_e  bus_snoop
);
	localparam int PTR_W = $clog2(`EVQ_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	cache_pkg::bus_evt_t mem [`EVQ_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    wr_ptr1;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic                pop;

	assign bus_valid = count != '0;
	assign pop       = bus_valid && bus_ready;
	assign evt.room  = count <= CNT_W'(`EVQ_DEPTH - 2);
	assign wr_ptr1   = wr_ptr + PTR_W'(evt.push0); // Slot for the second push

	assign bus_op    = mem[rd_ptr].op;
	assign bus_addr  = mem[rd_ptr].addr.raw;
	assign bus_snoop = mem[rd_ptr].snoop;

	always_ff @(posedge w_eof) begin
		if (evt.push0)
			mem[wr_ptr] <= evt.evt0;
		if (evt.push1)
			mem[wr_ptr1] <= evt.evt1;
	end

	always_ff @(posedge w_eof) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr1 + PTR_W'(evt.push1);
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CNT_W'(evt.push0) + CNT_W'(evt.push1) - CNT_W'(pop);
		end
	end

	a_no_overflow: assert property (@(posedge w_eof) disable iff (rst)
		evt.push0 || evt.push1 |-> evt.room)
		else $error("event pushed without room");

endmodule

// ==== verilog/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

`define CACHE_SETS 16
`define CACHE_WAYS 8
`define INDEX_W    4
`define OFFSET_W   6
`define TAG_W      22
`define WAY_W      3
`define PLRU_W     7
`define EVQ_DEPTH  4

// APB register map
`define REG_ADDR 8'h00
`define REG_CMD  8'h04
`define REG_RDS  8'h08
`define REG_WRS  8'h0C
`define REG_HITS 8'h10

`endif

// ==== verilog/cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

	typedef enum logic [3:0] {
		DATA_READ        = 4'd0,
		DATA_WRITE       = 4'd1,
		INST_READ        = 4'd2,
		SNOOP_INVALIDATE = 4'd3,
		SNOOP_READ       = 4'd4,
		SNOOP_RWIM       = 4'd6,
		CLEAR_CACHE      = 4'd8
	} cache_cmd_e;

	typedef enum logic [1:0] {I, S, E, M} mesi_e;

	typedef enum logic [2:0] {
		BUS_READ,
		BUS_WRITE,
		BUS_INVALIDATE,
		BUS_RWIM,
		SNOOP_REPLY
	} bus_op_e;

	typedef enum logic [1:0] {
		HIT   = 2'd0,
		HITM  = 2'd1,
		NOHIT = 2'd2
	} snoop_e;

	typedef struct packed {
		logic [`TAG_W-1:0]    tag;
		logic [`INDEX_W-1:0]  index;
		logic [`OFFSET_W-1:0] offset;
	} addr_fields_t;

	typedef union packed {
		logic [31:0]  raw;
		addr_fields_t f;
	} cache_addr_u;

	// snoop only carries meaning for SNOOP_REPLY
	typedef struct packed {
		bus_op_e     op;
		cache_addr_u addr;
		snoop_e      snoop;
	} bus_evt_t;

endpackage

// ==== verilog/cache_req_if.sv ====
`timescale 1ns/10ps

interface cache_req_if;
	logic                   valid;
	cache_pkg::cache_cmd_e  cmd;
	cache_pkg::cache_addr_u addr;
	logic                   ready;
	logic                   hit_valid; // One cycle after a processor command
	logic                   hit;

	modport port (
		output valid, cmd, addr,
		input  ready, hit_valid, hit
	);

	modport lookup (
		input  valid, cmd, addr,
		output ready, hit_valid, hit
	);
endinterface

// ==== verilog/cache_top.sv ====
`timescale 1ns/10ps

module cache_top (
	input  logic               w_eof,
	input  logic               rst,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [7:0]         paddr,
	input  logic [31:0]        pwdata,
	output logic [31:0]        prdata,
	output logic               pready,
	output logic               pslverr,
	output logic               bus_valid,
	input  logic               bus_ready,
	output cache_pkg::bus_op_e bus_op,
	output logic [31:0]        bus_addr,
	output cache_pkg::snoop_e  bus_snoop
);
	cache_req_if req_bus ();
	bus_evt_if   evt_bus ();

	apb_cmd_port u_apb (
		.w_eof   (w_eof),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.req     (req_bus.port)
	);

	mesi_lookup u_lookup (
		.w_eof (w_eof),
		.rst   (rst),
		.req   (req_bus.lookup),
		.evt   (evt_bus.src)
	);

	bus_event_queue u_evq (
		.w_eof     (w_eof),
		.rst       (rst),
		.evt       (evt_bus.sink),
		.bus_valid (bus_valid),
		.bus_ready (bus_ready),
		.bus_op    (bus_op),
		.bus_addr  (bus_addr),
		.bus_snoop (bus_snoop)
	);

endmodule

// ==== verilog/mesi_lookup.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module mesi_lookup (
	input  logic        w_eof,
	input  logic        rst,
	cache_req_if.lookup req,
	bus_evt_if.src      evt
);
	logic [`TAG_W-1:0]      tag_arr   [`CACHE_SETS][`CACHE_WAYS];
	cache_pkg::mesi_e       state_arr [`CACHE_SETS][`CACHE_WAYS];

	cache_pkg::cache_addr_u addr;
	cache_pkg::cache_addr_u victim_addr;
	logic [`INDEX_W-1:0]    idx;
	logic [`CACHE_WAYS-1:0] match;
	logic                   hit;
	logic [`WAY_W-1:0]      hit_way;
	logic [`WAY_W-1:0]      victim;
	logic [`WAY_W-1:0]      way;
	cache_pkg::mesi_e       cur_state;
	cache_pkg::mesi_e       new_state;
	cache_pkg::snoop_e      snoop_model;
	cache_pkg::bus_evt_t    req_evt;
	cache_pkg::bus_evt_t    wb_evt;
	logic                   req_evt_v;
	logic                   accept;
	logic                   is_read;
	logic                   is_write;
	logic                   is_proc;
	logic                   is_snoop;
	logic                   is_clear;
	logic                   fill;
	logic                   evict;
	logic                   wr_line;

	assign addr     = req.addr;
	assign idx      = addr.f.index;
	assign req.ready = evt.room;
	assign accept   = req.valid && req.ready;

	assign is_read  = req.cmd == cache_pkg::DATA_READ || req.cmd == cache_pkg::INST_READ;
	assign is_write = req.cmd == cache_pkg::DATA_WRITE;
	assign is_proc  = is_read || is_write;
	assign is_snoop = req.cmd == cache_pkg::SNOOP_READ || req.cmd == cache_pkg::SNOOP_RWIM ||
		req.cmd == cache_pkg::SNOOP_INVALIDATE;
	assign is_clear = req.cmd == cache_pkg::CLEAR_CACHE;

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			match[w] = state_arr[idx][w] != cache_pkg::I && tag_arr[idx][w] == addr.f.tag;
			if (match[w])
				hit_way = `WAY_W'(w);
		end
	end

	assign hit       = |match;
	assign way       = hit ? hit_way : victim;
	assign cur_state = state_arr[idx][way];

	// Other caches' answer modeled from the low address bits
	always_comb begin
		case (addr.raw[1:0])
			2'b00:   snoop_model = cache_pkg::HIT;
			2'b01:   snoop_model = cache_pkg::HITM;
			default: snoop_model = cache_pkg::NOHIT;
		endcase
	end

	assign victim_addr.raw = {tag_arr[idx][victim], idx, {`OFFSET_W{1'b0}}};
	assign wb_evt = '{op: cache_pkg::BUS_WRITE, addr: victim_addr, snoop: cache_pkg::NOHIT};

	always_comb begin
		req_evt.op    = cache_pkg::BUS_READ;
		req_evt.addr  = addr;
		req_evt.snoop = cache_pkg::NOHIT;
		req_evt_v     = 1'b0;
		new_state     = cur_state;
		if (is_proc && !hit) begin
			req_evt_v  = 1'b1;
			req_evt.op = is_write ? cache_pkg::BUS_RWIM : cache_pkg::BUS_READ;
			if (is_write)
				new_state = cache_pkg::M;
			else
				new_state = snoop_model == cache_pkg::NOHIT ? cache_pkg::E : cache_pkg::S;
		end else if (is_write) begin
			req_evt_v  = cur_state == cache_pkg::S; // E and M upgrade silently
			req_evt.op = cache_pkg::BUS_INVALIDATE;
			new_state  = cache_pkg::M;
		end else if (is_snoop) begin
			req_evt_v  = 1'b1;
			req_evt.op = cache_pkg::SNOOP_REPLY;
			if (!hit)
				req_evt.snoop = cache_pkg::NOHIT;
			else if (cur_state == cache_pkg::M)
				req_evt.snoop = cache_pkg::HITM;
			else
				req_evt.snoop = cache_pkg::HIT;
			case (req.cmd)
				cache_pkg::SNOOP_READ: new_state = cache_pkg::S;
				cache_pkg::SNOOP_RWIM: new_state = cache_pkg::I;
				default: begin
					if (cur_state == cache_pkg::S)
						new_state = cache_pkg::I;
				end
			endcase
		end
	end

	assign fill    = accept && is_proc && !hit;
	assign evict   = fill && state_arr[idx][victim] == cache_pkg::M; // Only dirty lines written back
	assign wr_line = accept && (is_proc || (is_snoop && hit));

	// Write-back goes out ahead of the fill request
	assign evt.push0 = accept && req_evt_v;
	assign evt.evt0  = evict ? wb_evt : req_evt;
	assign evt.push1 = evict;
	assign evt.evt1  = req_evt;

	always_ff @(posedge w_eof) begin
		if (rst || (accept && is_clear)) begin
			for (int s = 0; s < `CACHE_SETS; s++)
				for (int w = 0; w < `CACHE_WAYS; w++)
					state_arr[s][w] <= cache_pkg::I;
		end else if (wr_line) begin
			state_arr[idx][way] <= new_state;
		end
	end

	always_ff @(posedge w_eof) begin
		if (fill)
			tag_arr[idx][way] <= addr.f.tag;
	end

	always_ff @(posedge w_eof) begin
		if (rst)
			req.hit_valid <= 1'b0;
		else
			req.hit_valid <= accept && is_proc;
	end

	always_ff @(posedge w_eof) begin
		req.hit <= hit;
	end

	plru_tree u_plru (
		.w_eof       (w_eof),
		.rst         (rst),
		.clear       (accept && is_clear),
		.index       (idx),
		.victim      (victim),
		.touch       (accept && is_proc),
		.touch_index (idx),
		.touch_way   (way)
	);

	// A fill never duplicates a tag already live in the set
	a_one_match: assert property (@(posedge w_eof) disable iff (rst)
		req.valid |-> $onehot0(match))
		else $error("more than one way matches");

endmodule

// ==== verilog/plru_tree.sv ====
`timescale 1ns/10ps
`include "cache_macros.svh"

module plru_tree (
	input  logic                w_eof,
	input  logic                rst,
	input  logic                clear,
	input  logic [`INDEX_W-1:0] index,
	output logic [`WAY_W-1:0]   victim,
	input  logic                touch,
	input  logic [`INDEX_W-1:0] touch_index,
	input  logic [`WAY_W-1:0]   touch_way
);
	// Bit 0 root, bits 1-2 middle, bits 3-6 leaves
	logic [`PLRU_W-1:0] tree [`CACHE_SETS];
	logic [`PLRU_W-1:0] cur;

	assign cur = tree[index];

	// Walk away from the recently used side at every level
	always_comb begin
		victim[2] = ~cur[0];
		victim[1] = ~cur[1 + victim[2]];
		victim[0] = ~cur[3 + {victim[2], victim[1]}];
	end

	always_ff @(posedge w_eof) begin
		if (rst || clear) begin
			for (int s = 0; s < `CACHE_SETS; s++)
				tree[s] <= '0;
		end else if (touch) begin
			tree[touch_index][0]                   <= touch_way[2];
			tree[touch_index][1 + touch_way[2]]    <= touch_way[1];
			tree[touch_index][3 + touch_way[2:1]]  <= touch_way[0];
		end
	end

endmodule
